// ==== tb.f ====
common/addr_cmd_pkg.sv
source/pad_sequencer.sv
cmd_path/hr_to_fr_serializer.sv
cmd_path/cmd_pad_bank.sv
source/addr_cmd_pads.sv
test/addr_cmd_pads_asserts.sv
test/tb_addr_cmd_pads.sv

// ==== run.sh ====
#!/bin/sh
# compiles the testbench with Verilator, runs it and scans the log

set -u
cd "$(dirname "$0")" || exit 1

mkdir -p build
if [ $? -ne 0 ]; then
    echo "cannot create build directory"
    exit 1
fi

verilator --binary --timing --assert -f tb.f --top-module tb_addr_cmd_pads \
    -Mdir build/obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "compilation failed"
    exit 1
fi

build/obj_dir/sim_tb +verilator+error+limit+1000 > build/sim.log 2>&1
status=$?
cat build/sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" build/sim.log; then
    echo "simulation reported failure"
    exit 1
fi

exit 0

// ==== test/tb_addr_cmd_pads.sv ====
`timescale 1ns/1ns

module tb_addr_cmd_pads;
    import addr_cmd_pkg::*;

    localparam int NUM_MEM_CK = 2;
    // one command word for all nine groups with address on top and reset_n at the bottom
    localparam int BUNDLE_W   = 48;
    localparam int LOAD_TIMEOUT = 20;

    logic                  pll_mem_clk;
    logic                  rst_n;
    logic [NUM_MEM_CK-1:0] enable_mem_clk;
    afi_addr_t             afi_address;
    afi_bank_t             afi_bank;
    afi_ctl_t              afi_cs_n;
    afi_ctl_t              afi_cke;
    afi_ctl_t              afi_odt;
    afi_ctl_t              afi_ras_n;
    afi_ctl_t              afi_cas_n;
    afi_ctl_t              afi_we_n;
    afi_ctl_t              afi_reset_n;
    logic                  hr_load;
    mem_addr_t             mem_address;
    mem_bank_t             mem_bank;
    logic                  mem_cs_n;
    logic                  mem_cke;
    logic                  mem_odt;
    logic                  mem_ras_n;
    logic                  mem_cas_n;
    logic                  mem_we_n;
    logic                  mem_reset_n;
    logic                  cmd_oe;
    logic [NUM_MEM_CK-1:0] mem_ck_en;

    logic [31:0] lfsr_state;
    int          checks;
    int          errors;

    addr_cmd_pads #(
        .NUM_MEM_CK (NUM_MEM_CK)
    ) addr_cmd_pads_i (
        .pll_mem_clk    (pll_mem_clk),
        .rst_n          (rst_n),
        .enable_mem_clk (enable_mem_clk),
        .afi_address    (afi_address),
        .afi_bank       (afi_bank),
        .afi_cs_n       (afi_cs_n),
        .afi_cke        (afi_cke),
        .afi_odt        (afi_odt),
        .afi_ras_n      (afi_ras_n),
        .afi_cas_n      (afi_cas_n),
        .afi_we_n       (afi_we_n),
        .afi_reset_n    (afi_reset_n),
        .hr_load        (hr_load),
        .mem_address    (mem_address),
        .mem_bank       (mem_bank),
        .mem_cs_n       (mem_cs_n),
        .mem_cke        (mem_cke),
        .mem_odt        (mem_odt),
        .mem_ras_n      (mem_ras_n),
        .mem_cas_n      (mem_cas_n),
        .mem_we_n       (mem_we_n),
        .mem_reset_n    (mem_reset_n),
        .cmd_oe         (cmd_oe),
        .mem_ck_en      (mem_ck_en)
    );

    bind addr_cmd_pads addr_cmd_pads_asserts #(
        .NUM_MEM_CK (NUM_MEM_CK)
    ) addr_cmd_pads_asserts_i (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .hr_load     (hr_load),
        .mem_address (mem_address),
        .mem_bank    (mem_bank),
        .mem_cs_n    (mem_cs_n),
        .mem_cke     (mem_cke),
        .mem_odt     (mem_odt),
        .mem_ras_n   (mem_ras_n),
        .mem_cas_n   (mem_cas_n),
        .mem_we_n    (mem_we_n),
        .mem_reset_n (mem_reset_n),
        .cmd_oe      (cmd_oe),
        .mem_ck_en   (mem_ck_en)
    );

    always #10 pll_mem_clk = ~pll_mem_clk;

    // ************************************************************
    // stimulus helpers
    // ************************************************************

    // right-shifting galois form with taps at bits 32 22 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [BUNDLE_W-1:0] random_bits(input int count);
        logic [BUNDLE_W-1:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            bits = {bits[BUNDLE_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    task automatic drive_word(input logic [BUNDLE_W-1:0] word);
        afi_address = word[47:20];
        afi_bank    = word[19:14];
        afi_cs_n    = word[13:12];
        afi_cke     = word[11:10];
        afi_odt     = word[9:8];
        afi_ras_n   = word[7:6];
        afi_cas_n   = word[5:4];
        afi_we_n    = word[3:2];
        afi_reset_n = word[1:0];
    endtask

    // returns 2 ns after the edge that raised hr_load, so the next edge captures
    task automatic wait_for_load(output bit found);
        int cycles;
        found = 1'b0;
        cycles = 0;
        while (!found && cycles < LOAD_TIMEOUT)
        begin
            @(posedge pll_mem_clk);
            #2;
            cycles++;
            found = hr_load;
        end
        if (!found)
        begin
            errors++;
            $display("hr_load did not rise within %0d cycles at %0t", LOAD_TIMEOUT, $time);
        end
    endtask

    // ************************************************************
    // checks
    // ************************************************************

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("error %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // compares the pins with one slot where slot 0 is the lower half of each group word
    task automatic check_pins(input logic [BUNDLE_W-1:0] word, input int slot);
        logic [13:0] exp_addr;
        logic [2:0]  exp_bank;
        logic [6:0]  exp_ctl;
        if (slot == 0)
        begin
            exp_addr = word[33:20];
            exp_bank = word[16:14];
            exp_ctl  = {word[12], word[10], word[8], word[6], word[4], word[2], word[0]};
        end
        else
        begin
            exp_addr = word[47:34];
            exp_bank = word[19:17];
            exp_ctl  = {word[13], word[11], word[9], word[7], word[5], word[3], word[1]};
        end
        compare("mem_address", 32'(mem_address), 32'(exp_addr));
        compare("mem_bank", 32'(mem_bank), 32'(exp_bank));
        compare("mem_cs_n", 32'(mem_cs_n), 32'(exp_ctl[6]));
        compare("mem_cke", 32'(mem_cke), 32'(exp_ctl[5]));
        compare("mem_odt", 32'(mem_odt), 32'(exp_ctl[4]));
        compare("mem_ras_n", 32'(mem_ras_n), 32'(exp_ctl[3]));
        compare("mem_cas_n", 32'(mem_cas_n), 32'(exp_ctl[2]));
        compare("mem_we_n", 32'(mem_we_n), 32'(exp_ctl[1]));
        compare("mem_reset_n", 32'(mem_reset_n), 32'(exp_ctl[0]));
    endtask

    // idle pins deselect the memory and issue a NOP with cke low and the memory in reset
    task automatic check_idle();
        compare("mem_address", 32'(mem_address), 32'h0);
        compare("mem_bank", 32'(mem_bank), 32'h0);
        compare("mem_cs_n", 32'(mem_cs_n), 32'h1);
        compare("mem_ras_n", 32'(mem_ras_n), 32'h1);
        compare("mem_cas_n", 32'(mem_cas_n), 32'h1);
        compare("mem_we_n", 32'(mem_we_n), 32'h1);
        compare("mem_cke", 32'(mem_cke), 32'h0);
        compare("mem_odt", 32'(mem_odt), 32'h0);
        compare("mem_reset_n", 32'(mem_reset_n), 32'h0);
        compare("cmd_oe", 32'(cmd_oe), 32'h0);
        compare("mem_ck_en", 32'(mem_ck_en), 32'h0);
    endtask

    // ************************************************************
    // directed tests
    // ************************************************************

    task automatic test_reset_state();
        for (int i = 0; i < 10; i++)
        begin
            @(negedge pll_mem_clk);
            compare("hr_load", 32'(hr_load), 32'h0);
            check_idle();
        end
        @(posedge pll_mem_clk);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic test_strobe_cadence();
        int  cycles;
        bit  found;
        found = 1'b0;
        cycles = 0;
        // pins stay idle up to and including the first strobe cycle
        while (!found && cycles < LOAD_TIMEOUT)
        begin
            @(posedge pll_mem_clk);
            cycles++;
            @(negedge pll_mem_clk);
            found = hr_load;
            check_idle();
        end
        if (!found)
        begin
            errors++;
            $display("first hr_load did not come after reset release");
        end
        compare("first hr_load delay", 32'(cycles), 32'd3);
        for (int k = 0; k < 8; k++)
        begin
            found = 1'b0;
            cycles = 0;
            while (!found && cycles < LOAD_TIMEOUT)
            begin
                @(posedge pll_mem_clk);
                cycles++;
                @(negedge pll_mem_clk);
                found = hr_load;
            end
            compare("hr_load spacing", 32'(cycles), 32'd2);
        end
    endtask

    task automatic test_slot_order();
        logic [BUNDLE_W-1:0] word;
        bit                  found;
        for (int i = 0; i < 8; i++)
        begin
            wait_for_load(found);
            word = random_bits(BUNDLE_W);
            drive_word(word);
            @(posedge pll_mem_clk);
            #2;
            // the source may move on once its word has been captured
            drive_word(~word);
            @(negedge pll_mem_clk);
            check_pins(word, 0);
            @(posedge pll_mem_clk);
            @(negedge pll_mem_clk);
            check_pins(word, 1);
        end
    endtask

    task automatic test_stream();
        logic [BUNDLE_W-1:0] word;
        logic [BUNDLE_W-1:0] prev;
        bit                  found;
        prev = '0;
        for (int i = 0; i < 32; i++)
        begin
            wait_for_load(found);
            word = random_bits(BUNDLE_W);
            drive_word(word);
            @(negedge pll_mem_clk);
            if (i > 0)
                check_pins(prev, 1);
            @(posedge pll_mem_clk);
            @(negedge pll_mem_clk);
            check_pins(word, 0);
            prev = word;
        end
        @(posedge pll_mem_clk);
        @(negedge pll_mem_clk);
        check_pins(prev, 1);
    endtask

    task automatic test_enables();
        logic [BUNDLE_W-1:0]   word;
        logic [NUM_MEM_CK-1:0] pattern;
        bit                    found;
        for (int i = 0; i < 6; i++)
        begin
            case (i)
                0, 4:    pattern = 2'b00;
                1:       pattern = 2'b01;
                2:       pattern = 2'b10;
                3:       pattern = 2'b11;
                default: pattern = NUM_MEM_CK'(random_bits(NUM_MEM_CK));
            endcase
            wait_for_load(found);
            word = random_bits(BUNDLE_W);
            drive_word(word);
            enable_mem_clk = pattern;
            for (int slot = 0; slot < 2; slot++)
            begin
                @(posedge pll_mem_clk);
                @(negedge pll_mem_clk);
                compare("mem_ck_en", 32'(mem_ck_en), 32'(pattern));
                compare("cmd_oe", 32'(cmd_oe), 32'(pattern != '0));
                check_pins(word, slot);
            end
        end
    endtask

    initial
    begin
        int assert_fails;
        lfsr_state     = 32'hcad0_248a;
        checks         = 0;
        errors         = 0;
        pll_mem_clk    = 1'b0;
        rst_n          = 1'b0;
        enable_mem_clk = '0;
        // busy inputs show that nothing reaches the pins before the first capture
        drive_word(random_bits(BUNDLE_W));
        test_reset_state();
        test_strobe_cadence();
        test_slot_order();
        test_stream();
        test_enables();
        repeat (2) @(posedge pll_mem_clk);
        assert_fails = int'(addr_cmd_pads_i.addr_cmd_pads_asserts_i.fail_count);
        $display("checks %0d, check errors %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== test/addr_cmd_pads_asserts.sv ====
`timescale 1ns/1ns

module addr_cmd_pads_asserts #(
    parameter int NUM_MEM_CK = 1
) (
    input logic                     pll_mem_clk,
    input logic                     rst_n,
    input logic                     hr_load,
    input addr_cmd_pkg::mem_addr_t  mem_address,
    input addr_cmd_pkg::mem_bank_t  mem_bank,
    input logic                     mem_cs_n,
    input logic                     mem_cke,
    input logic                     mem_odt,
    input logic                     mem_ras_n,
    input logic                     mem_cas_n,
    input logic                     mem_we_n,
    input logic                     mem_reset_n,
    input logic                     cmd_oe,
    input logic [NUM_MEM_CK-1:0]    mem_ck_en
);
    import addr_cmd_pkg::*;

    int unsigned fail_count = 0;
    logic        clock_seen = 1'b0;
    logic        outputs_idle;

    // the first edge applies reset, so idle is only expected from the second on
    always @(posedge pll_mem_clk)
        clock_seen <= 1'b1;

    assign outputs_idle = !hr_load && !cmd_oe && (mem_ck_en == '0)
                       && (mem_address == '0) && (mem_bank == '0)
                       && mem_cs_n && mem_ras_n && mem_cas_n && mem_we_n
                       && !mem_cke && !mem_odt && !mem_reset_n;

    // one strobe per half-rate cycle
    assert property (@(posedge pll_mem_clk) disable iff (!rst_n) hr_load |=> !hr_load)
    else
    begin
        fail_count++;
        $error("hr_load high in two consecutive cycles");
    end

    assert property (@(posedge pll_mem_clk) (!rst_n && clock_seen) |-> outputs_idle)
    else
    begin
        fail_count++;
        $error("outputs left their idle values while rst_n is low");
    end

endmodule

// ==== source/addr_cmd_pads.sv ====
`timescale 1ns/1ns

module addr_cmd_pads #(
    parameter int NUM_MEM_CK = 1
) (
    input  logic                                pll_mem_clk,
    input  logic                                rst_n,
    input  logic [NUM_MEM_CK-1:0]               enable_mem_clk,
    input  addr_cmd_pkg::afi_addr_t             afi_address,
    input  addr_cmd_pkg::afi_bank_t             afi_bank,
    input  addr_cmd_pkg::afi_ctl_t              afi_cs_n,
    input  addr_cmd_pkg::afi_ctl_t              afi_cke,
    input  addr_cmd_pkg::afi_ctl_t              afi_odt,
    input  addr_cmd_pkg::afi_ctl_t              afi_ras_n,
    input  addr_cmd_pkg::afi_ctl_t              afi_cas_n,
    input  addr_cmd_pkg::afi_ctl_t              afi_we_n,
    input  addr_cmd_pkg::afi_ctl_t              afi_reset_n,
    output logic                                hr_load,
    output addr_cmd_pkg::mem_addr_t             mem_address,
    output addr_cmd_pkg::mem_bank_t             mem_bank,
    output logic [addr_cmd_pkg::MEM_CS_W-1:0]   mem_cs_n,
    output logic [addr_cmd_pkg::MEM_CKE_W-1:0]  mem_cke,
    output logic [addr_cmd_pkg::MEM_ODT_W-1:0]  mem_odt,
    output logic                                mem_ras_n,
    output logic                                mem_cas_n,
    output logic                                mem_we_n,
    output logic                                mem_reset_n,
    output logic                                cmd_oe,
    output logic [NUM_MEM_CK-1:0]               mem_ck_en
);

    // second half-rate phase, slot 1 goes to the pins
    logic slot_sel;

    // ************************************************************
    // phase generation and enables
    // ************************************************************

    pad_sequencer #(
        .NUM_MEM_CK (NUM_MEM_CK)
    ) pad_sequencer_i (
        .pll_mem_clk    (pll_mem_clk),
        .rst_n          (rst_n),
        .enable_mem_clk (enable_mem_clk),
        .hr_load        (hr_load),
        .slot_sel       (slot_sel),
        .mem_ck_en      (mem_ck_en),
        .cmd_oe         (cmd_oe)
    );

    // ************************************************************
    // half-rate to full-rate lanes
    // ************************************************************

    // the source presents a fresh word at every hr_load, there is no stall
    cmd_pad_bank cmd_pad_bank_i (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .hr_load     (hr_load),
        .slot_sel    (slot_sel),
        .afi_address (afi_address),
        .afi_bank    (afi_bank),
        .afi_cs_n    (afi_cs_n),
        .afi_cke     (afi_cke),
        .afi_odt     (afi_odt),
        .afi_ras_n   (afi_ras_n),
        .afi_cas_n   (afi_cas_n),
        .afi_we_n    (afi_we_n),
        .afi_reset_n (afi_reset_n),
        .mem_address (mem_address),
        .mem_bank    (mem_bank),
        .mem_cs_n    (mem_cs_n),
        .mem_cke     (mem_cke),
        .mem_odt     (mem_odt),
        .mem_ras_n   (mem_ras_n),
        .mem_cas_n   (mem_cas_n),
        .mem_we_n    (mem_we_n),
        .mem_reset_n (mem_reset_n)
    );

endmodule

// ==== cmd_path/cmd_pad_bank.sv ====
`timescale 1ns/1ns

module cmd_pad_bank (
    input  logic                                pll_mem_clk,
    input  logic                                rst_n,
    input  logic                                hr_load,
    input  logic                                slot_sel,
    input  addr_cmd_pkg::afi_addr_t             afi_address,
    input  addr_cmd_pkg::afi_bank_t             afi_bank,
    input  addr_cmd_pkg::afi_ctl_t              afi_cs_n,
    input  addr_cmd_pkg::afi_ctl_t              afi_cke,
    input  addr_cmd_pkg::afi_ctl_t              afi_odt,
    input  addr_cmd_pkg::afi_ctl_t              afi_ras_n,
    input  addr_cmd_pkg::afi_ctl_t              afi_cas_n,
    input  addr_cmd_pkg::afi_ctl_t              afi_we_n,
    input  addr_cmd_pkg::afi_ctl_t              afi_reset_n,
    output addr_cmd_pkg::mem_addr_t             mem_address,
    output addr_cmd_pkg::mem_bank_t             mem_bank,
    output logic [addr_cmd_pkg::MEM_CS_W-1:0]   mem_cs_n,
    output logic [addr_cmd_pkg::MEM_CKE_W-1:0]  mem_cke,
    output logic [addr_cmd_pkg::MEM_ODT_W-1:0]  mem_odt,
    output logic                                mem_ras_n,
    output logic                                mem_cas_n,
    output logic                                mem_we_n,
    output logic                                mem_reset_n
);
    import addr_cmd_pkg::*;

    // ************************************************************
    // address and bank lanes
    // ************************************************************

    hr_to_fr_serializer #(.WIDTH(MEM_ADDR_W), .IDLE_VALUE(IDLE_ADDR)) address_ser_i (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .load        (hr_load),
        .slot_sel    (slot_sel),
        .word        (afi_address),
        .pin         (mem_address)
    );

    hr_to_fr_serializer #(.WIDTH(MEM_BANK_W), .IDLE_VALUE(IDLE_BANK)) bank_ser_i (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .load        (hr_load),
        .slot_sel    (slot_sel),
        .word        (afi_bank),
        .pin         (mem_bank)
    );

    // ************************************************************
    // command lanes
    // ************************************************************

    hr_to_fr_serializer #(.WIDTH(MEM_CS_W), .IDLE_VALUE(IDLE_CS_N)) cs_n_ser_i (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .load        (hr_load),
        .slot_sel    (slot_sel),
        .word        (afi_cs_n),
        .pin         (mem_cs_n)
    );

    hr_to_fr_serializer #(.WIDTH(1), .IDLE_VALUE(IDLE_CMD_N)) ras_n_ser_i (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .load        (hr_load),
        .slot_sel    (slot_sel),
        .word        (afi_ras_n),
        .pin         (mem_ras_n)
    );

    hr_to_fr_serializer #(.WIDTH(1), .IDLE_VALUE(IDLE_CMD_N)) cas_n_ser_i (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .load        (hr_load),
        .slot_sel    (slot_sel),
        .word        (afi_cas_n),
        .pin         (mem_cas_n)
    );

    hr_to_fr_serializer #(.WIDTH(1), .IDLE_VALUE(IDLE_CMD_N)) we_n_ser_i (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .load        (hr_load),
        .slot_sel    (slot_sel),
        .word        (afi_we_n),
        .pin         (mem_we_n)
    );

    hr_to_fr_serializer #(.WIDTH(MEM_ODT_W), .IDLE_VALUE(IDLE_ODT)) odt_ser_i (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .load        (hr_load),
        .slot_sel    (slot_sel),
        .word        (afi_odt),
        .pin         (mem_odt)
    );

    // cke and reset_n are driven even while the memory clocks are off
    hr_to_fr_serializer #(.WIDTH(MEM_CKE_W), .IDLE_VALUE(IDLE_CKE)) cke_ser_i (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .load        (hr_load),
        .slot_sel    (slot_sel),
        .word        (afi_cke),
        .pin         (mem_cke)
    );

    hr_to_fr_serializer #(.WIDTH(1), .IDLE_VALUE(IDLE_RESET_N)) reset_n_ser_i (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .load        (hr_load),
        .slot_sel    (slot_sel),
        .word        (afi_reset_n),
        .pin         (mem_reset_n)
    );

endmodule

// ==== cmd_path/hr_to_fr_serializer.sv ====
`timescale 1ns/1ns

module hr_to_fr_serializer #(
    parameter int               WIDTH      = 1,
    parameter logic [WIDTH-1:0] IDLE_VALUE = '0
) (
    input  logic               pll_mem_clk,
    input  logic               rst_n,
    input  logic               load,
    input  logic               slot_sel,
    input  logic [2*WIDTH-1:0] word,
    output logic [WIDTH-1:0]   pin
);

    logic [WIDTH-1:0] slot0;
    logic [WIDTH-1:0] slot1;
    logic [WIDTH-1:0] slot1_hold;

    // slot 0 is the lower half of the half-rate word and leaves first
    assign slot0 = word[WIDTH-1:0];
    assign slot1 = word[2*WIDTH-1:WIDTH];

    // upper half waits one full-rate cycle for its turn on the pin
    always_ff @(posedge pll_mem_clk)
    begin
        if (load)
        begin
            slot1_hold <= slot1;
        end
    end

    // ************************************************************
    // full-rate pin register
    // ************************************************************

    // load and slot_sel never overlap, the phase machine keeps them apart
    // and the pin holds its value when neither is set
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pin <= IDLE_VALUE;
        end
        else if (load)
        begin
            pin <= slot0;
        end
        else if (slot_sel)
        begin
            pin <= slot1_hold;
        end
    end

endmodule

// ==== source/pad_sequencer.sv ====
`timescale 1ns/1ns

module pad_sequencer #(
    parameter int NUM_MEM_CK = 1
) (
    input  logic                  pll_mem_clk,
    input  logic                  rst_n,
    input  logic [NUM_MEM_CK-1:0] enable_mem_clk,
    output logic                  hr_load,
    output logic                  slot_sel,
    output logic [NUM_MEM_CK-1:0] mem_ck_en,
    output logic                  cmd_oe
);
    import addr_cmd_pkg::*;

    logic [1:0] rst_sync;
    hr_phase_t  phase;
    hr_phase_t  phase_next;

    // ************************************************************
    // reset release and half-rate phase
    // ************************************************************

    // reset release goes through two flops before the phase machine starts
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rst_sync <= 2'b00;
        end
        else
        begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    // the first load phase follows the synchronised release, after that
    // the machine never returns to idle while reset stays high
    always_comb
    begin
        phase_next = phase;
        case (phase)
            PH_IDLE:   if (rst_sync[1]) phase_next = PH_LOAD;
            PH_LOAD:   phase_next = PH_SECOND;
            PH_SECOND: phase_next = PH_LOAD;
            default:   phase_next = PH_IDLE;
        endcase
    end

    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase <= PH_IDLE;
        end
        else
        begin
            phase <= phase_next;
        end
    end

    // slot 0 is loaded with the word, slot 1 goes out in the second phase
    assign hr_load  = (phase == PH_LOAD);
    assign slot_sel = (phase == PH_SECOND);

    // ************************************************************
    // memory clock enables and the command output enable
    // ************************************************************

    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mem_ck_en <= '0;
            cmd_oe    <= 1'b0;
        end
        else
        begin
            mem_ck_en <= enable_mem_clk;
            // address and command drive as long as any memory clock runs
            cmd_oe    <= |enable_mem_clk;
        end
    end

endmodule

// ==== common/addr_cmd_pkg.sv ====
package addr_cmd_pkg;

    // ************************************************************
    // memory side pin counts
    // ************************************************************

    localparam int MEM_ADDR_W = 14;
    localparam int MEM_BANK_W = 3;
    localparam int MEM_CS_W   = 1;
    localparam int MEM_CKE_W  = 1;
    localparam int MEM_ODT_W  = 1;

    // one full-rate slot as it appears on the memory pins
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [MEM_BANK_W-1:0] mem_bank_t;

    // half-rate words carry two slots, slot 0 sits in the lower half
    typedef logic [2*MEM_ADDR_W-1:0] afi_addr_t;
    typedef logic [2*MEM_BANK_W-1:0] afi_bank_t;

    // half-rate word of any one-bit command pin
    typedef logic [1:0] afi_ctl_t;

    // phase of the half-rate cycle as seen by the full-rate clock
    typedef enum logic [1:0]
    {
        PH_IDLE,
        PH_LOAD,
        PH_SECOND
    } hr_phase_t;

    // ************************************************************
    // pin values held from reset until the first capture
    // ************************************************************

    localparam mem_addr_t IDLE_ADDR = '0;
    localparam mem_bank_t IDLE_BANK = '0;

    // deselect and NOP on the command pins
    localparam logic [MEM_CS_W-1:0] IDLE_CS_N = '1;
    localparam logic IDLE_CMD_N = 1'b1;

    // memory stays powered down and in reset
    localparam logic [MEM_CKE_W-1:0] IDLE_CKE = '0;
    localparam logic [MEM_ODT_W-1:0] IDLE_ODT = '0;
    localparam logic IDLE_RESET_N = 1'b0;

endpackage
